/* hdl/mmem_dpram.sv */
/*
 * Dual-port synchronous RAM for the M-memory, one clock for both ports.
 * Registered read per port; a port A write wins over a port B write.
 */

`timescale 1ns/100ps

module mmem_dpram
#(
   parameter int ADDR_WIDTH = 5,
   parameter int DATA_WIDTH = 32
)
(
   input  logic                  clk_a,
   input  logic                  reset,

   input  logic [ADDR_WIDTH-1:0] address_a,
   input  logic [DATA_WIDTH-1:0] data_a,
   input  logic                  wren_a,
   input  logic                  rden_a,
   output logic [DATA_WIDTH-1:0] q_a,

   input  logic [ADDR_WIDTH-1:0] address_b,
   input  logic [DATA_WIDTH-1:0] data_b,
   input  logic                  wren_b,
   input  logic                  rden_b,
   output logic [DATA_WIDTH-1:0] q_b
);

   logic [DATA_WIDTH-1:0] ram [0:(2**ADDR_WIDTH)-1];

   // one write per cycle with port A first
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
         ram[address_a] <= data_a;
      else if (wren_b)
         ram[address_b] <= data_b;
   end

   // read registers hold their value while not enabled
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= ram[address_a];  // old data on a same-edge write
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= ram[address_b];
   end

endmodule

/* hdl/mmem_issue.sv */
/*
 * Command issue stage of the M-memory unit.
 * Zeroes the RAM after reset, then turns accepted commands into RAM port
 * accesses and read requests for the result stage.
 */

`timescale 1ns/100ps

module mmem_issue
   import mmem_pkg::*;
#(
   parameter int ADDR_WIDTH = 5,
   parameter int DATA_WIDTH = 32
)
(
   input  logic                  clk_a,
   input  logic                  reset,

   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   input  mmem_op_t              cmd_op,
   input  logic [ADDR_WIDTH-1:0] cmd_addr,
   input  logic [DATA_WIDTH-1:0] cmd_data,

   output logic [ADDR_WIDTH-1:0] address_a,
   output logic [DATA_WIDTH-1:0] data_a,
   output logic                  wren_a,

   output logic [ADDR_WIDTH-1:0] rd_addr,
   output logic                  rden_b,

   output logic                  rd_issue,
   output mmem_op_t              rd_op,
   output logic [DATA_WIDTH-1:0] rd_operand,

   input  logic                  slot_ready
);

   issue_state_t          state;
   logic [ADDR_WIDTH-1:0] clr_cnt;
   logic                  clearing;
   logic                  needs_slot;
   logic                  accept;
   logic                  is_write_a;

   assign clearing   = (state == st_clear);
   assign needs_slot = (cmd_op != op_write);  // read, add, swap return a result

   // writes go through even with a full result queue
   assign cmd_ready = (state == st_run) && (!needs_slot || slot_ready);
   assign accept    = cmd_valid && cmd_ready;

   assign is_write_a = (cmd_op == op_write) || (cmd_op == op_swap);

   // port A carries the clear sweep or write/swap data
   always_comb
   begin
      if (clearing)
      begin
         address_a = clr_cnt;
         data_a    = '0;
         wren_a    = 1'b1;
      end
      else
      begin
         address_a = cmd_addr;
         data_a    = cmd_data;
         wren_a    = accept && is_write_a;
      end
   end

   // port B read and request toward the result stage
   assign rd_issue   = accept && needs_slot;
   assign rden_b     = rd_issue;
   assign rd_addr    = cmd_addr;
   assign rd_op      = cmd_op;
   assign rd_operand = cmd_data;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state   <= st_clear;
         clr_cnt <= '0;
      end
      else
      begin
         case (state)
            st_clear:
            begin
               clr_cnt <= clr_cnt + 1'b1;
               if (clr_cnt == {ADDR_WIDTH{1'b1}})  // last word zeroed
                  state <= st_run;
            end
            st_run:
            begin
               if (accept && cmd_op == op_add)
                  state <= st_rmw;  // port B busy with the sum next cycle
            end
            st_rmw:
               state <= st_run;
            default:
               state <= st_run;
         endcase
      end
   end

endmodule

/* hdl/mmem_pkg.sv */
/*
 * Shared types for the M-memory scratchpad unit.
 * Import into any module or testbench that handles commands or issue state.
 */

package mmem_pkg;

   // command opcodes carried on the command stream
   typedef enum logic [1:0]
   {
      op_write = 2'd0,  // store data at address
      op_read  = 2'd1,  // return the word
      op_add   = 2'd2,  // return word plus data, store the sum
      op_swap  = 2'd3   // return old word, store data
   } mmem_op_t;

   // issue stage FSM states
   typedef enum logic [1:0]
   {
      st_clear = 2'd0,  // zeroing sweep after reset
      st_run   = 2'd1,
      st_rmw   = 2'd2   // add write-back owns port B
   } issue_state_t;

endpackage

/* hdl/mmem_result.sv */
/*
 * Result stage of the M-memory unit.
 * Takes RAM read data one cycle after issue, writes add sums back through
 * port B and queues results in a two-entry FIFO for the result stream.
 */

`timescale 1ns/100ps

module mmem_result
   import mmem_pkg::*;
#(
   parameter int ADDR_WIDTH = 5,
   parameter int DATA_WIDTH = 32
)
(
   input  logic                  clk_a,
   input  logic                  reset,

   input  logic                  rd_issue,
   input  mmem_op_t              rd_op,
   input  logic [ADDR_WIDTH-1:0] rd_addr,
   input  logic [DATA_WIDTH-1:0] rd_operand,

   input  logic [DATA_WIDTH-1:0] q_b,

   output logic [ADDR_WIDTH-1:0] address_b,
   output logic [DATA_WIDTH-1:0] data_b,
   output logic                  wren_b,

   output logic                  slot_ready,

   output logic                  res_valid,
   input  logic                  res_ready,
   output logic [DATA_WIDTH-1:0] res_data
);

   logic                  inflight;
   mmem_op_t              op_q;
   logic [ADDR_WIDTH-1:0] addr_q;
   logic [DATA_WIDTH-1:0] operand_q;
   logic [DATA_WIDTH-1:0] result;

   logic [DATA_WIDTH-1:0] fifo_mem [0:1];
   logic                  wr_ptr;
   logic                  rd_ptr;
   logic [1:0]            count;
   logic                  push;
   logic                  pop;

   always_ff @(posedge clk_a)
   begin
      if (reset)
         inflight <= 1'b0;
      else
         inflight <= rd_issue;  // q_b valid next cycle
   end

   always_ff @(posedge clk_a)
   begin
      if (rd_issue)
      begin
         op_q      <= rd_op;
         addr_q    <= rd_addr;
         operand_q <= rd_operand;
      end
   end

   // sum wraps at DATA_WIDTH bits
   assign result = (op_q == op_add) ? q_b + operand_q : q_b;

   // issue leaves port B idle during the write-back
   assign wren_b    = inflight && (op_q == op_add);
   assign data_b    = result;
   assign address_b = wren_b ? addr_q : rd_addr;

   assign push = inflight;
   assign pop  = res_valid && res_ready;

   always_ff @(posedge clk_a)
   begin
      if (push)
         fifo_mem[wr_ptr] <= result;
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= ~wr_ptr;
         if (pop)
            rd_ptr <= ~rd_ptr;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   assign res_valid = (count != 2'd0);
   assign res_data  = fifo_mem[rd_ptr];

   // room for one more, counting the read still in the RAM
   assign slot_ready = (count + {1'b0, inflight}) < 2'd2;

endmodule

/* hdl/mmem_unit.sv */
/*
 * M-memory scratchpad unit, top level.
 * Command stream in, ordered read results out; sets the RAM geometry.
 */

`timescale 1ns/100ps

module mmem_unit
   import mmem_pkg::*;
#(
   parameter int ADDR_WIDTH = 5,
   parameter int DATA_WIDTH = 32
)
(
   input  logic                  clk_a,
   input  logic                  reset,

   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   input  mmem_op_t              cmd_op,
   input  logic [ADDR_WIDTH-1:0] cmd_addr,
   input  logic [DATA_WIDTH-1:0] cmd_data,

   output logic                  res_valid,
   input  logic                  res_ready,
   output logic [DATA_WIDTH-1:0] res_data
);

   logic [ADDR_WIDTH-1:0] address_a;
   logic [DATA_WIDTH-1:0] data_a;
   logic                  wren_a;
   logic [ADDR_WIDTH-1:0] address_b;
   logic [DATA_WIDTH-1:0] data_b;
   logic                  wren_b;
   logic                  rden_b;
   logic [DATA_WIDTH-1:0] q_b;

   logic                  rd_issue;
   mmem_op_t              rd_op;
   logic [ADDR_WIDTH-1:0] rd_addr;
   logic [DATA_WIDTH-1:0] rd_operand;
   logic                  slot_ready;

   mmem_issue #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) issue_inst
   (
      .clk_a      (clk_a),
      .reset      (reset),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd_op     (cmd_op),
      .cmd_addr   (cmd_addr),
      .cmd_data   (cmd_data),
      .address_a  (address_a),
      .data_a     (data_a),
      .wren_a     (wren_a),
      .rd_addr    (rd_addr),
      .rden_b     (rden_b),
      .rd_issue   (rd_issue),
      .rd_op      (rd_op),
      .rd_operand (rd_operand),
      .slot_ready (slot_ready)
   );

   // port A is write only here
   mmem_dpram #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) dpram_inst
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (address_a),
      .data_a    (data_a),
      .wren_a    (wren_a),
      .rden_a    (1'b0),
      .q_a       (),
      .address_b (address_b),
      .data_b    (data_b),
      .wren_b    (wren_b),
      .rden_b    (rden_b),
      .q_b       (q_b)
   );

   mmem_result #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) result_inst
   (
      .clk_a      (clk_a),
      .reset      (reset),
      .rd_issue   (rd_issue),
      .rd_op      (rd_op),
      .rd_addr    (rd_addr),
      .rd_operand (rd_operand),
      .q_b        (q_b),
      .address_b  (address_b),
      .data_b     (data_b),
      .wren_b     (wren_b),
      .slot_ready (slot_ready),
      .res_valid  (res_valid),
      .res_ready  (res_ready),
      .res_data   (res_data)
   );

endmodule

/* mmem.f */
hdl/mmem_pkg.sv
hdl/mmem_dpram.sv
hdl/mmem_issue.sv
hdl/mmem_result.sv
hdl/mmem_unit.sv
tests/mmem_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the M-memory unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module mmem_unit_tb -f mmem.f -o mmem_sim
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

output=$(./obj_dir/mmem_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
   exit 0
fi
echo "pass message not found"
exit 1

/* tests/mmem_unit_tb.sv */
/*
 * Testbench for the M-memory unit. Checks the reset and clear sweep, then runs
 * directed and random commands against a model array, with result back-pressure.
 */

`timescale 1ns/100ps

module mmem_unit_tb
   import mmem_pkg::*;
();

   localparam int ADDR_WIDTH = 5;
   localparam int DATA_WIDTH = 32;
   localparam int DEPTH      = 2**ADDR_WIDTH;
   localparam int N_RANDOM   = 60;
   localparam int N_CMDS     = DEPTH + 5 * N_RANDOM + 12;  // all phases together
   localparam int LIMIT      = 4 * (8 + DEPTH + N_CMDS) + 100;

   logic                  clk_a;
   logic                  reset;
   logic                  cmd_valid;
   logic                  cmd_ready;
   mmem_op_t              cmd_op;
   logic [ADDR_WIDTH-1:0] cmd_addr;
   logic [DATA_WIDTH-1:0] cmd_data;
   logic                  res_valid;
   logic                  res_ready;
   logic [DATA_WIDTH-1:0] res_data;

   logic [DATA_WIDTH-1:0] model [0:DEPTH-1];
   logic [DATA_WIDTH-1:0] exp_q [$];   // results owed in command order
   logic [DATA_WIDTH-1:0] exp_data;
   logic [31:0]           stall_r;
   logic                  running;
   logic                  after_add;
   logic                  exp_ready;
   int                    clear_cycles;
   int                    errors;
   int                    cycles;
   int                    seed;
   int                    stall_seed;
   int                    ready_mode;  // 0 held low, 1 high, 2 random stalls

   mmem_unit #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) mmem_unit_inst
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_op    (cmd_op),
      .cmd_addr  (cmd_addr),
      .cmd_data  (cmd_data),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_data  (res_data)
   );

   initial
   begin
      clk_a = 1'b0;
      forever #20 clk_a = ~clk_a;
   end

   always @(posedge clk_a)
   begin
      stall_r = $random(stall_seed);
      case (ready_mode)
         0:       res_ready <= 1'b0;
         1:       res_ready <= 1'b1;
         default: res_ready <= stall_r[0];
      endcase
   end

   initial
   begin
      cycles = 0;
      while (cycles < LIMIT)
      begin
         @(posedge clk_a);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   task automatic log_error(input string msg);
      errors++;
      $display("ERR %0t: %s", $time, msg);
   endtask

   // a stalled result stays offered and unchanged
   assert property (@(posedge clk_a) disable iff (reset)
      res_valid && !res_ready |=> res_valid && $stable(res_data))
   else log_error("result changed or dropped while res_ready was low");

   // drive one command and return at the negedge before the accepting edge
   task automatic issue_cmd(input mmem_op_t op, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data);
      @(posedge clk_a);
      cmd_valid <= 1'b1;
      cmd_op    <= op;
      cmd_addr  <= addr;
      cmd_data  <= data;
      @(negedge clk_a);
      while (!cmd_ready)
         @(negedge clk_a);
   endtask

   task automatic issue_random(input int n, input logic all_ops);
      logic [31:0] r;
      mmem_op_t    op;
      repeat (n)
      begin
         r = $random(seed);
         if (all_ops)
            op = mmem_op_t'(r[1:0]);
         else
            op = r[0] ? op_read : op_write;
         issue_cmd(op, r[ADDR_WIDTH+1:2], $random(seed));
      end
   endtask

   task automatic drain_results();
      @(posedge clk_a);
      cmd_valid <= 1'b0;
      while (exp_q.size() != 0)
         @(negedge clk_a);
      @(negedge clk_a);
   endtask

   // checks and model updates on the negedge before the edge that acts
   always @(negedge clk_a)
   begin
      if (reset)
      begin
         assert (!cmd_ready && !res_valid)
         else log_error("cmd_ready or res_valid high during reset");
      end
      else if (!running)
      begin
         if (cmd_ready)
         begin
            assert (clear_cycles == DEPTH)
            else log_error($sformatf("clear sweep took %0d cycles", clear_cycles));
            running = 1'b1;
         end
         else
            clear_cycles++;
      end
      if (running)
      begin
         exp_ready = !after_add && (cmd_op == op_write || exp_q.size() < 2);
         assert (cmd_ready == exp_ready)
         else log_error($sformatf("cmd_ready %0b, expected %0b", cmd_ready, exp_ready));
         assert (exp_q.size() <= 2)
         else log_error($sformatf("%0d results pending", exp_q.size()));
         assert (!res_valid || exp_q.size() != 0)
         else log_error("result offered with no command outstanding");
         if (res_valid && res_ready && exp_q.size() != 0)
         begin
            exp_data = exp_q.pop_front();
            assert (res_data == exp_data)
            else log_error($sformatf("res_data %h, expected %h", res_data, exp_data));
         end
         after_add = 1'b0;
         if (cmd_valid && cmd_ready)
         begin
            case (cmd_op)
               op_write: model[cmd_addr] = cmd_data;
               op_read:  exp_q.push_back(model[cmd_addr]);
               op_add:
               begin
                  model[cmd_addr] = model[cmd_addr] + cmd_data;  // wraps at 32 bits
                  exp_q.push_back(model[cmd_addr]);
                  after_add = 1'b1;
               end
               default:  // swap
               begin
                  exp_q.push_back(model[cmd_addr]);
                  model[cmd_addr] = cmd_data;
               end
            endcase
         end
      end
   end

   initial
   begin
      seed         = 59690;
      stall_seed   = seed;
      errors       = 0;
      clear_cycles = 0;
      running      = 1'b0;
      after_add    = 1'b0;
      ready_mode   = 1;
      reset        = 1'b1;
      cmd_valid    = 1'b0;
      cmd_op       = op_write;
      cmd_addr     = '0;
      cmd_data     = '0;
      res_ready    = 1'b0;
      for (int k = 0; k < DEPTH; k++)
         model[k] = '0;  // what the clear sweep leaves behind
      repeat (8) @(posedge clk_a);
      reset <= 1'b0;
      while (!running)
         @(negedge clk_a);

      for (int k = 0; k < DEPTH; k++)
         issue_cmd(op_read, k[ADDR_WIDTH-1:0], '0);

      issue_cmd(op_write, 5'd9, 32'hDEAD_BEEF);
      issue_cmd(op_read, 5'd9, '0);
      issue_random(N_RANDOM, 1'b0);

      issue_cmd(op_write, 5'd5, 32'hFFFF_FFF0);
      issue_cmd(op_add, 5'd5, 32'h0000_0020);   // sum wraps to 0x10
      issue_cmd(op_read, 5'd5, '0);
      issue_cmd(op_swap, 5'd6, 32'h0000_ABCD);
      issue_cmd(op_read, 5'd6, '0);
      issue_random(N_RANDOM, 1'b1);

      ready_mode = 2;
      issue_random(3 * N_RANDOM, 1'b1);
      drain_results();

      // fill the queue, then a read must stall and a write must not
      ready_mode = 0;
      issue_cmd(op_read, 5'd3, '0);
      issue_cmd(op_read, 5'd4, '0);
      @(posedge clk_a);
      cmd_op   <= op_read;
      cmd_addr <= 5'd7;
      repeat (4) @(negedge clk_a);
      issue_cmd(op_write, 5'd3, 32'h5A5A_1234);
      ready_mode = 1;
      issue_cmd(op_read, 5'd3, '0);
      drain_results();

      $display("run complete, %0d error(s)", errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule
